// File: hdl/mem_pkg.sv
package mem_pkg;

    // ========================================
    // basic widths
    // ========================================
    typedef logic [31:0] addr_t;  // byte address.
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;  // one bit per byte lane.

    // ========================================
    // cache line geometry
    // ========================================
    localparam int LINE_WORDS     = 4;
    localparam int OFFSET_WIDTH   = 4;  // byte offset inside a line.
    localparam int WORD_SEL_WIDTH = 2;  // word index inside a line.

    // word 0 sits in the low 32 bits.
    typedef logic [LINE_WORDS*32-1:0] line_t;

endpackage

// File: hdl/axi_pkg.sv
package axi_pkg;

    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;   // beats minus one.
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;

    // ids tell the two requesters apart on the R channel.
    localparam axi_id_t AXI_ID_INST = 4'd0;
    localparam axi_id_t AXI_ID_DATA = 4'd1;

    localparam axi_size_t  SIZE_WORD  = 3'd2;  // 4 bytes per beat.
    localparam axi_burst_t BURST_INCR = 2'd1;

endpackage

// File: hdl/icache.sv
module icache
    import mem_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  addr_t addr,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_rdy,
    input  logic  ret_valid,
    input  logic  ret_last,
    input  word_t ret_data
);

    localparam int SETS      = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH = 32 - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} state_t;

    state_t                    state;
    logic [TAG_WIDTH-1:0]      tag_mem [SETS];
    line_t                     data_mem [SETS];
    logic [SETS-1:0]           valid_q;
    addr_t                     req_addr;
    logic                      req_sent;  // line request taken by the bridge.
    logic [WORD_SEL_WIDTH-1:0] fill_cnt;
    logic [TAG_WIDTH-1:0]      req_tag;
    logic [INDEX_WIDTH-1:0]    req_index;
    logic [WORD_SEL_WIDTH-1:0] req_sel;
    logic                      hit;

    assign req_tag   = req_addr[31 -: TAG_WIDTH];
    assign req_index = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_sel   = req_addr[2 +: WORD_SEL_WIDTH];
    assign hit       = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    assign addr_ok = (state == IDLE);
    assign data_ok = (state == LOOKUP && hit) || (state == RESPOND);
    assign rdata   = data_mem[req_index][req_sel*32 +: 32];
    assign rd_req  = (state == REFILL) && !req_sent;
    assign rd_addr = {req_addr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};  // line aligned.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            req_sent <= 1'b0;
            fill_cnt <= '0;
            valid_q  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) state <= LOOKUP;
                end
                LOOKUP: begin
                    req_sent <= 1'b0;
                    fill_cnt <= '0;
                    state    <= hit ? IDLE : REFILL;
                end
                REFILL: begin
                    if (rd_req && rd_rdy) req_sent <= 1'b1;
                    if (ret_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (ret_last) begin
                            valid_q[req_index] <= 1'b1;
                            state              <= RESPOND;
                        end
                    end
                end
                default: state <= IDLE;  // respond lasts one cycle.
            endcase
        end
    end

    // beats arrive in line order, word 0 first.
    always_ff @(posedge clk) begin
        if (state == IDLE && req) req_addr <= addr;
        if (state == REFILL && ret_valid) begin
            data_mem[req_index][fill_cnt*32 +: 32] <= ret_data;
            if (ret_last) tag_mem[req_index] <= req_tag;
        end
    end

endmodule

// File: hdl/dcache.sv
module dcache
    import mem_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    input  logic  wr,
    input  strb_t wstrb,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  uncached,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata,
    output logic  rd_req,
    output logic  rd_line,
    output addr_t rd_addr,
    input  logic  rd_rdy,
    input  logic  ret_valid,
    input  logic  ret_last,
    input  word_t ret_data,
    output logic  wr_req,
    output addr_t wr_addr,
    output strb_t wr_wstrb,
    output word_t wr_data,
    input  logic  wr_rdy
);

    localparam int SETS      = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH = 32 - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, WRITE, RESPOND} state_t;

    state_t                    state;
    logic [TAG_WIDTH-1:0]      tag_mem [SETS];
    line_t                     data_mem [SETS];
    logic [SETS-1:0]           valid_q;
    addr_t                     req_addr;
    logic                      req_wr, req_unc;
    strb_t                     req_wstrb;
    word_t                     req_wdata;
    word_t                     unc_data;  // word from an uncached read.
    logic                      req_sent;
    logic [WORD_SEL_WIDTH-1:0] fill_cnt;
    logic [TAG_WIDTH-1:0]      req_tag;
    logic [INDEX_WIDTH-1:0]    req_index;
    logic [WORD_SEL_WIDTH-1:0] req_sel;
    logic                      line_hit, hit;

    assign req_tag   = req_addr[31 -: TAG_WIDTH];
    assign req_index = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_sel   = req_addr[2 +: WORD_SEL_WIDTH];
    assign line_hit  = valid_q[req_index] && (tag_mem[req_index] == req_tag);
    assign hit       = line_hit && !req_unc;  // uncached reads always go out.

    assign addr_ok = (state == IDLE);
    assign data_ok = (state == LOOKUP && !req_wr && hit) || (state == RESPOND);
    assign rdata   = req_unc ? unc_data : data_mem[req_index][req_sel*32 +: 32];

    assign rd_req  = (state == REFILL) && !req_sent;
    assign rd_line = !req_unc;
    assign rd_addr = req_unc ? {req_addr[31:2], 2'b00}
                             : {req_addr[31:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign wr_req   = (state == WRITE);
    assign wr_addr  = {req_addr[31:2], 2'b00};
    assign wr_wstrb = req_wstrb;
    assign wr_data  = req_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            req_sent <= 1'b0;
            fill_cnt <= '0;
            valid_q  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) state <= LOOKUP;
                end
                LOOKUP: begin
                    req_sent <= 1'b0;
                    fill_cnt <= '0;
                    if (req_wr)   state <= WRITE;  // stores never allocate.
                    else if (hit) state <= IDLE;
                    else          state <= REFILL;
                end
                REFILL: begin
                    if (rd_req && rd_rdy) req_sent <= 1'b1;
                    if (ret_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (ret_last) begin
                            if (!req_unc) valid_q[req_index] <= 1'b1;
                            state <= RESPOND;
                        end
                    end
                end
                WRITE: begin
                    if (wr_rdy) state <= RESPOND;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_addr  <= addr;
            req_wr    <= wr;
            req_unc   <= uncached;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if (state == REFILL && ret_valid) begin
            if (req_unc) begin
                unc_data <= ret_data;
            end else begin
                data_mem[req_index][fill_cnt*32 +: 32] <= ret_data;
                if (ret_last) tag_mem[req_index] <= req_tag;
            end
        end
        // keep a resident line in step with memory.
        if (state == LOOKUP && req_wr && line_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (req_wstrb[b]) begin
                    data_mem[req_index][req_sel*32 + b*8 +: 8] <= req_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/axi_bridge.sv
module axi_bridge
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       inst_rd_req,
    input  addr_t      inst_rd_addr,
    output logic       inst_rd_rdy,
    output logic       inst_ret_valid,
    output logic       inst_ret_last,
    output word_t      inst_ret_data,

    input  logic       data_rd_req,
    input  logic       data_rd_line,
    input  addr_t      data_rd_addr,
    output logic       data_rd_rdy,
    output logic       data_ret_valid,
    output logic       data_ret_last,
    output word_t      data_ret_data,
    input  logic       data_wr_req,
    input  addr_t      data_wr_addr,
    input  strb_t      data_wr_wstrb,
    input  word_t      data_wr_data,
    output logic       data_wr_rdy,

    output axi_id_t    arid,
    output addr_t      araddr,
    output axi_len_t   arlen,
    output axi_size_t  arsize,
    output axi_burst_t arburst,
    output logic       arvalid,
    input  logic       arready,
    input  axi_id_t    rid,
    input  word_t      rdata,
    input  axi_resp_t  rresp,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,
    output axi_id_t    awid,
    output addr_t      awaddr,
    output axi_len_t   awlen,
    output axi_size_t  awsize,
    output axi_burst_t awburst,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  axi_id_t    bid,
    input  axi_resp_t  bresp,
    input  logic       bvalid,
    output logic       bready
);

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_t;
    typedef enum logic [1:0] {W_IDLE, W_SEND, W_RESP} wr_state_t;

    rd_state_t rd_state;
    wr_state_t wr_state;
    logic      data_rd_go, inst_rd_go, data_wr_go;
    logic      aw_done, w_done;

    // ========================================
    // read channel
    // ========================================
    // a data read waits for any write still in flight.
    assign data_rd_rdy = (rd_state == R_IDLE) && (wr_state == W_IDLE);
    assign data_rd_go  = data_rd_req && data_rd_rdy;
    assign inst_rd_rdy = (rd_state == R_IDLE) && !data_rd_go;  // data side first.
    assign inst_rd_go  = inst_rd_req && inst_rd_rdy;

    assign arsize  = SIZE_WORD;
    assign arburst = BURST_INCR;
    assign arvalid = (rd_state == R_ADDR);
    assign rready  = (rd_state == R_DATA);

    assign inst_ret_valid = rvalid && rready && (rid == AXI_ID_INST);
    assign data_ret_valid = rvalid && rready && (rid == AXI_ID_DATA);
    assign inst_ret_last  = rlast;
    assign data_ret_last  = rlast;
    assign inst_ret_data  = rdata;
    assign data_ret_data  = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE: if (data_rd_go || inst_rd_go) rd_state <= R_ADDR;
                R_ADDR: if (arready) rd_state <= R_DATA;
                R_DATA: if (rvalid && rlast) rd_state <= R_IDLE;
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd_go) begin
            arid   <= AXI_ID_DATA;
            araddr <= data_rd_addr;
            arlen  <= data_rd_line ? 8'd3 : 8'd0;
        end else if (inst_rd_go) begin
            arid   <= AXI_ID_INST;
            araddr <= inst_rd_addr;
            arlen  <= 8'd3;  // instruction side always fills a line.
        end
    end

    // ========================================
    // write channel
    // ========================================
    assign data_wr_rdy = (wr_state == W_IDLE);
    assign data_wr_go  = data_wr_req && data_wr_rdy;

    assign awid    = AXI_ID_DATA;
    assign awlen   = 8'd0;
    assign awsize  = SIZE_WORD;
    assign awburst = BURST_INCR;
    assign wlast   = 1'b1;
    assign awvalid = (wr_state == W_SEND) && !aw_done;
    assign wvalid  = (wr_state == W_SEND) && !w_done;
    assign bready  = (wr_state == W_RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= W_IDLE;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (data_wr_go) wr_state <= W_SEND;
                end
                W_SEND: begin
                    if (awvalid && awready) aw_done <= 1'b1;
                    if (wvalid && wready)   w_done  <= 1'b1;
                    if ((aw_done || awready) && (w_done || wready)) wr_state <= W_RESP;
                end
                W_RESP: if (bvalid && bid == AXI_ID_DATA) wr_state <= W_IDLE;
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr_go) begin
            awaddr <= data_wr_addr;
            wdata  <= data_wr_data;
            wstrb  <= data_wr_wstrb;
        end
    end

endmodule

// File: hdl/cache_axi_top.sv
module cache_axi_top
    import mem_pkg::*;
    import axi_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic       aclk,
    input  logic       rst_n,

    // instruction side
    input  logic       inst_req,
    input  addr_t      inst_addr,
    output logic       inst_addr_ok,
    output logic       inst_data_ok,
    output word_t      inst_rdata,

    // data side
    input  logic       data_req,
    input  logic       data_wr,
    input  strb_t      data_wstrb,
    input  addr_t      data_addr,
    input  word_t      data_wdata,
    input  logic       data_uncached,
    output logic       data_addr_ok,
    output logic       data_data_ok,
    output word_t      data_rdata,

    // AXI master
    output axi_id_t    arid,
    output addr_t      araddr,
    output axi_len_t   arlen,
    output axi_size_t  arsize,
    output axi_burst_t arburst,
    output logic       arvalid,
    input  logic       arready,
    input  axi_id_t    rid,
    input  word_t      rdata,
    input  axi_resp_t  rresp,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,
    output axi_id_t    awid,
    output addr_t      awaddr,
    output axi_len_t   awlen,
    output axi_size_t  awsize,
    output axi_burst_t awburst,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  axi_id_t    bid,
    input  axi_resp_t  bresp,
    input  logic       bvalid,
    output logic       bready
);

    logic  inst_rd_req, inst_rd_rdy, inst_ret_valid, inst_ret_last;
    addr_t inst_rd_addr;
    word_t inst_ret_data;

    logic  data_rd_req, data_rd_line, data_rd_rdy, data_ret_valid, data_ret_last;
    addr_t data_rd_addr, data_wr_addr;
    word_t data_ret_data, data_wr_data;
    logic  data_wr_req, data_wr_rdy;
    strb_t data_wr_wstrb;

    icache #(.INDEX_WIDTH(INDEX_WIDTH)) icache_inst (
        .clk       (aclk),
        .rst_n     (rst_n),
        .req       (inst_req),
        .addr      (inst_addr),
        .addr_ok   (inst_addr_ok),
        .data_ok   (inst_data_ok),
        .rdata     (inst_rdata),
        .rd_req    (inst_rd_req),
        .rd_addr   (inst_rd_addr),
        .rd_rdy    (inst_rd_rdy),
        .ret_valid (inst_ret_valid),
        .ret_last  (inst_ret_last),
        .ret_data  (inst_ret_data)
    );

    dcache #(.INDEX_WIDTH(INDEX_WIDTH)) dcache_inst (
        .clk       (aclk),
        .rst_n     (rst_n),
        .req       (data_req),
        .wr        (data_wr),
        .wstrb     (data_wstrb),
        .addr      (data_addr),
        .wdata     (data_wdata),
        .uncached  (data_uncached),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .rdata     (data_rdata),
        .rd_req    (data_rd_req),
        .rd_line   (data_rd_line),
        .rd_addr   (data_rd_addr),
        .rd_rdy    (data_rd_rdy),
        .ret_valid (data_ret_valid),
        .ret_last  (data_ret_last),
        .ret_data  (data_ret_data),
        .wr_req    (data_wr_req),
        .wr_addr   (data_wr_addr),
        .wr_wstrb  (data_wr_wstrb),
        .wr_data   (data_wr_data),
        .wr_rdy    (data_wr_rdy)
    );

    // bridge port names match the wires and AXI ports above.
    axi_bridge axi_bridge_inst (
        .clk (aclk),
        .*
    );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: testbench/axi_mem_model.sv
module axi_mem_model
    import mem_pkg::*;
    import axi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axi_id_t   arid,
    input  addr_t     araddr,
    input  axi_len_t  arlen,
    input  logic      arvalid,
    output logic      arready,
    output axi_id_t   rid,
    output word_t     rdata,
    output axi_resp_t rresp,
    output logic      rlast,
    output logic      rvalid,
    input  logic      rready,
    input  axi_id_t   awid,
    input  addr_t     awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  word_t     wdata,
    input  strb_t     wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_id_t   bid,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    output int        ar_count,
    output int        w_count,
    output axi_len_t  last_arlen
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t FILL = 32'h5a3c_96e1;  // unwritten word is address xor this.

    word_t    mem [addr_t];
    integer   seed = 30008;
    logic     rd_busy, aw_seen, w_seen;
    addr_t    rd_base, aw_addr_q;
    axi_len_t rd_len, beat;
    word_t    w_data_q;
    strb_t    w_strb_q;

    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) return mem[a];
        return a ^ FILL;
    endfunction

    function automatic bit coin();
        return ($random(seed) & 3) != 0;  // high three times in four.
    endfunction

    // ========================================
    // read and write channels
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rid        <= '0;
            rdata      <= '0;
            rresp      <= '0;
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            bid        <= '0;
            bresp      <= '0;
            rd_busy    <= 1'b0;
            aw_seen    <= 1'b0;
            w_seen     <= 1'b0;
            beat       <= '0;
            ar_count   <= 0;
            w_count    <= 0;
            last_arlen <= '0;
        end else begin
            arready <= !rd_busy && coin();
            if (arvalid && arready) begin
                rd_busy    <= 1'b1;
                rd_base    <= araddr;
                rd_len     <= arlen;
                rid        <= arid;
                beat       <= '0;
                arready    <= 1'b0;
                ar_count   <= ar_count + 1;
                last_arlen <= arlen;
            end
            if (rd_busy) begin
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                    if (rlast) rd_busy <= 1'b0;
                    else       beat    <= beat + 8'd1;
                end else if (!rvalid && coin()) begin
                    rvalid <= 1'b1;
                    rdata  <= read_word(rd_base + {22'd0, beat, 2'b00});
                    rlast  <= (beat == rd_len);
                end
            end

            awready <= !aw_seen && coin();
            wready  <= !w_seen && coin();
            if (awvalid && awready) begin
                aw_seen   <= 1'b1;
                aw_addr_q <= awaddr;
                bid       <= awid;
                awready   <= 1'b0;
            end
            if (wvalid && wready) begin
                w_seen   <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
                wready   <= 1'b0;
                w_count  <= w_count + 1;
            end
            if (aw_seen && w_seen && !bvalid) begin
                word_t cur;
                cur = read_word(aw_addr_q);
                for (int b = 0; b < 4; b++) begin
                    if (w_strb_q[b]) cur[b*8 +: 8] = w_data_q[b*8 +: 8];
                end
                mem[aw_addr_q] = cur;
                bvalid <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_cache_axi_top.sv
module tb_cache_axi_top
    import mem_pkg::*;
    import axi_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t FILL      = 32'h5a3c_96e1;
    localparam bit    SIDE_INST = 1'b0;
    localparam bit    SIDE_DATA = 1'b1;

    typedef struct {
        string name;
        bit    side;
        bit    wr;
        bit    unc;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        int    ars;  // AR handshakes expected during the test.
    } test_t;

    logic       clk, rst_n;
    logic       inst_req, inst_addr_ok, inst_data_ok;
    addr_t      inst_addr;
    word_t      inst_rdata;
    logic       data_req, data_wr, data_uncached, data_addr_ok, data_data_ok;
    strb_t      data_wstrb;
    addr_t      data_addr;
    word_t      data_wdata, data_rdata;
    axi_id_t    arid, rid, awid, bid;
    addr_t      araddr, awaddr;
    axi_len_t   arlen, awlen, last_arlen;
    axi_size_t  arsize, awsize;
    axi_burst_t arburst, awburst;
    axi_resp_t  rresp, bresp;
    logic       arvalid, arready, rlast, rvalid, rready;
    logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t      rdata, wdata;
    strb_t      wstrb;
    int         ar_count, w_count;

    test_t tests[$];
    word_t shadow [addr_t];
    string cur_name        = "reset";
    int    data_errors     = 0;
    int    count_errors    = 0;
    int    protocol_errors = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) clock_inst (.clk(clk), .rst_n(rst_n));

    axi_mem_model mem_inst (.*);

    cache_axi_top #(.INDEX_WIDTH(4)) cache_axi_top_inst (.aclk(clk), .*);

    function automatic word_t shadow_read(input addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ FILL;
    endfunction

    function automatic void shadow_store(input addr_t a, input word_t d, input strb_t s);
        word_t cur;
        cur = shadow_read(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) cur[b*8 +: 8] = d[b*8 +: 8];
        end
        shadow[a] = cur;
    endfunction

    task automatic add(input string name, input bit side, input bit wr, input bit unc,
                       input addr_t addr, input word_t wdata, input strb_t strb, input int ars);
        test_t t;
        t.name = name;
        t.side = side;
        t.wr = wr;
        t.unc = unc;
        t.addr = addr;
        t.wdata = wdata;
        t.strb = strb;
        t.ars = ars;
        tests.push_back(t);
    endtask

    // ========================================
    // test table
    // ========================================
    task automatic build_table();
        add("inst_miss",      SIDE_INST, 0, 0, 32'h0000_1000, '0, 4'h0, 1);
        add("inst_hit",       SIDE_INST, 0, 0, 32'h0000_1008, '0, 4'h0, 0);
        add("data_miss",      SIDE_DATA, 0, 0, 32'h0000_2004, '0, 4'h0, 1);
        add("data_hit",       SIDE_DATA, 0, 0, 32'h0000_200c, '0, 4'h0, 0);
        add("data_conflict",  SIDE_DATA, 0, 0, 32'h0000_2104, '0, 4'h0, 1);
        add("conflict_hit",   SIDE_DATA, 0, 0, 32'h0000_2100, '0, 4'h0, 0);
        add("data_refill",    SIDE_DATA, 0, 0, 32'h0000_2000, '0, 4'h0, 1);
        add("store_hit",      SIDE_DATA, 1, 0, 32'h0000_2000, 32'hcafe_babe, 4'hf, 0);
        add("load_after_hit", SIDE_DATA, 0, 0, 32'h0000_2000, '0, 4'h0, 0);
        add("store_miss",     SIDE_DATA, 1, 0, 32'h0000_3008, 32'h1234_5678, 4'hf, 0);
        add("load_no_alloc",  SIDE_DATA, 0, 0, 32'h0000_3008, '0, 4'h0, 1);
        add("store_bytes",    SIDE_DATA, 1, 0, 32'h0000_3004, 32'h1122_3344, 4'h5, 0);
        add("load_bytes",     SIDE_DATA, 0, 0, 32'h0000_3004, '0, 4'h0, 0);
        add("store_top_byte", SIDE_DATA, 1, 0, 32'h0000_2000, 32'h9900_0000, 4'h8, 0);
        add("load_top_byte",  SIDE_DATA, 0, 0, 32'h0000_2000, '0, 4'h0, 1);
        add("unc_cached",     SIDE_DATA, 0, 1, 32'h0000_2004, '0, 4'h0, 1);
        add("hit_after_unc",  SIDE_DATA, 0, 0, 32'h0000_2008, '0, 4'h0, 0);
        add("unc_cold",       SIDE_DATA, 0, 1, 32'h0000_4000, '0, 4'h0, 1);
        add("cold_after_unc", SIDE_DATA, 0, 0, 32'h0000_4000, '0, 4'h0, 1);
        add("mix_inst_0",     SIDE_INST, 0, 0, 32'h0000_1010, '0, 4'h0, 1);
        add("mix_data_0",     SIDE_DATA, 0, 0, 32'h0000_5000, '0, 4'h0, 1);
        add("mix_inst_1",     SIDE_INST, 0, 0, 32'h0000_1014, '0, 4'h0, 0);
        add("mix_data_1",     SIDE_DATA, 0, 0, 32'h0000_5008, '0, 4'h0, 0);
        add("mix_inst_2",     SIDE_INST, 0, 0, 32'h0000_1004, '0, 4'h0, 0);
        add("mix_data_2",     SIDE_DATA, 0, 0, 32'h0000_3000, '0, 4'h0, 1);
        add("mix_inst_3",     SIDE_INST, 0, 0, 32'h0000_1110, '0, 4'h0, 1);
        add("mix_data_3",     SIDE_DATA, 1, 0, 32'h0000_5004, 32'h0bad_f00d, 4'h3, 0);
        add("mix_data_4",     SIDE_DATA, 0, 0, 32'h0000_5004, '0, 4'h0, 1);
    endtask

    task automatic run_test(input test_t t);
        int    ar_before;
        int    w_before;
        int    waits;
        word_t got;
        word_t exp;
        cur_name  = t.name;
        ar_before = ar_count;
        w_before  = w_count;
        @(posedge clk);
        if (t.side == SIDE_INST) begin
            inst_req  <= 1'b1;
            inst_addr <= t.addr;
        end else begin
            data_req      <= 1'b1;
            data_wr       <= t.wr;
            data_uncached <= t.unc;
            data_addr     <= t.addr;
            data_wdata    <= t.wdata;
            data_wstrb    <= t.strb;
        end
        @(negedge clk);
        while (!(t.side == SIDE_INST ? inst_addr_ok : data_addr_ok)) @(negedge clk);
        @(posedge clk);
        inst_req <= 1'b0;
        data_req <= 1'b0;
        @(negedge clk);
        waits = 0;
        while (!(t.side == SIDE_INST ? inst_data_ok : data_data_ok)) begin
            @(negedge clk);
            waits++;
        end
        got = (t.side == SIDE_INST) ? inst_rdata : data_rdata;

        // a hit answers in the cycle after the request.
        if (!t.wr && t.ars == 0 && waits != 0) begin
            $display("mismatch %s: expected hit latency 1, actual %0d", t.name, waits + 1);
            protocol_errors++;
        end

        if (t.wr) begin
            shadow_store(t.addr, t.wdata, t.strb);
            while (!(bvalid && bready)) @(negedge clk);  // store done once B returns.
            if (w_count - w_before != 1) begin
                $display("mismatch %s: expected %0d W beats, actual %0d",
                         t.name, 1, w_count - w_before);
                count_errors++;
            end
        end else begin
            exp = shadow_read(t.addr);
            if (got !== exp) begin
                $display("mismatch %s: expected %h, actual %h", t.name, exp, got);
                data_errors++;
            end
        end
        if (ar_count - ar_before != t.ars) begin
            $display("mismatch %s: expected %0d AR, actual %0d",
                     t.name, t.ars, ar_count - ar_before);
            count_errors++;
        end
        if (t.ars == 1 && last_arlen !== (t.unc ? 8'd0 : 8'd3)) begin
            $display("mismatch %s: expected arlen %0d, actual %0d",
                     t.name, t.unc ? 0 : 3, last_arlen);
            count_errors++;
        end
    endtask

    // ========================================
    // fixed AXI fields
    // ========================================
    always @(negedge clk) begin
        if (arvalid && arready && (arsize !== 3'd2 || arburst !== 2'd1)) begin
            $display("mismatch %s: expected arsize 2 arburst 1, actual arsize %0d arburst %0d",
                     cur_name, arsize, arburst);
            protocol_errors++;
        end
        if (awvalid && awready && (awlen !== 8'd0 || awsize !== 3'd2 || awburst !== 2'd1)) begin
            $display("mismatch %s: expected awlen 0 awsize 2 awburst 1, actual %0d %0d %0d",
                     cur_name, awlen, awsize, awburst);
            protocol_errors++;
        end
        if (wvalid && wready && wlast !== 1'b1) begin
            $display("mismatch %s: expected wlast 1, actual %b", cur_name, wlast);
            protocol_errors++;
        end
    end

    initial begin
        inst_req      = 1'b0;
        inst_addr     = '0;
        data_req      = 1'b0;
        data_wr       = 1'b0;
        data_uncached = 1'b0;
        data_addr     = '0;
        data_wdata    = '0;
        data_wstrb    = '0;
        build_table();
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        foreach (tests[i]) run_test(tests[i]);
        repeat (4) @(posedge clk);
        $display("errors: data %0d, count %0d, protocol %0d",
                 data_errors, count_errors, protocol_errors);
        if (data_errors == 0 && count_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // ========================================
    // watchdog
    // ========================================
    initial begin
        wait (rst_n === 1'b1);  // table is built by now.
        repeat (tests.size() * 300) @(posedge clk);
        $display("timeout: the tests did not complete in %0d cycles", tests.size() * 300);
        $display("errors: data %0d, count %0d, protocol %0d",
                 data_errors, count_errors, protocol_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: cache_axi_top.f
hdl/mem_pkg.sv
hdl/axi_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/axi_bridge.sv
hdl/cache_axi_top.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_model.sv
testbench/tb_cache_axi_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_cache_axi_top
FILELIST  ?= cache_axi_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
